/* Bender.yml */
package:
  name: lsu

sources:
  - include_dirs:
      - hw
    files:
      - hw/rv_mem_pkg.sv
      - hw/lsu_pkg.sv
      - hw/lsu_align.sv
      - hw/lsu_access_fsm.sv
      - hw/lsu_load_extend.sv
      - hw/dmem_ram.sv
      - hw/lsu_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - tb/lsu_assertions.sv
      - tb/lsu_tb.sv

/* files.f */
+incdir+hw
hw/rv_mem_pkg.sv
hw/lsu_pkg.sv
hw/lsu_align.sv
hw/lsu_access_fsm.sv
hw/lsu_load_extend.sv
hw/dmem_ram.sv
hw/lsu_top.sv
tb/lsu_assertions.sv
tb/lsu_tb.sv

/* hw/dmem_ram.sv */
// Word-organised data RAM with per-byte write enables
// Answers each accepted request with one ready pulse LSU_DMEM_LAT cycles later
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defines.svh"

module dmem_ram (
	input  logic                 i_clk,
	input  logic                 i_rst_n,
	input  lsu_pkg::word_idx_t   i_addr,
	input  logic                 i_wen,
	input  logic                 i_ren,
	input  rv_mem_pkg::byte_en_t i_byte_en,
	input  rv_mem_pkg::word_t    i_wdata,
	output rv_mem_pkg::word_t    o_rdata,
	output logic                 o_ready
);

	localparam int DEPTH = 2 ** `LSU_DMEM_AW;
	localparam int CW    = $clog2(`LSU_DMEM_LAT + 1);

	rv_mem_pkg::word_t mem [DEPTH];
	logic [CW-1:0] cnt; // Cycles left until ready

	// Array and read register
	always_ff @(posedge i_clk) begin
		if (i_wen) begin
			for (int i = 0; i < 4; i++) begin
				if (i_byte_en[i]) begin
					mem[i_addr][8*i +: 8] <= i_wdata[8*i +: 8];
				end
			end
		end
		if (i_ren) begin
			o_rdata <= mem[i_addr]; // Held until the next read
		end
	end

	// Latency counter
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			cnt <= '0;
		end else if (i_wen || i_ren) begin
			cnt <= CW'(`LSU_DMEM_LAT);
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
		end
	end

	assign o_ready = (cnt == CW'(1));

endmodule

`default_nettype wire

/* hw/lsu_access_fsm.sv */
// Access stage: IDLE/READ/WRITE machine that issues RAM requests
// Holds the core in stall until the RAM ready pulse arrives
`timescale 1ns/1ns
`default_nettype none

module lsu_access_fsm (
	input  logic i_clk,
	input  logic i_rst_n,
	input  logic i_wr_en,
	input  logic i_rd_en,
	input  logic i_ex_ld,
	input  logic i_ex_st,
	input  logic i_ready,
	output logic o_mem_wen,
	output logic o_mem_ren,
	output logic o_stall
);

	lsu_pkg::acc_state_e state;
	lsu_pkg::acc_state_e next_state;
	logic ex;
	logic req;

	assign ex  = i_ex_ld || i_ex_st;
	assign req = i_wr_en || i_rd_en;

	always_ff @(posedge i_clk) begin
		if (!i_rst_n || ex) begin // Exception aborts the access
			state <= lsu_pkg::IDLE;
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			lsu_pkg::IDLE: begin
				if (i_rd_en) begin
					next_state = lsu_pkg::READ;
				end
				if (i_wr_en) begin
					next_state = lsu_pkg::WRITE;
				end
			end
			lsu_pkg::READ, lsu_pkg::WRITE: begin
				if (i_ready) begin
					next_state = lsu_pkg::IDLE;
				end
			end
			default: begin
				next_state = lsu_pkg::IDLE;
			end
		endcase
	end

	// Request goes out once, in the IDLE cycle, and only if aligned
	assign o_mem_wen = (state == lsu_pkg::IDLE) && i_wr_en && !i_ex_st;
	assign o_mem_ren = (state == lsu_pkg::IDLE) && i_rd_en && !i_ex_ld;

	// Low again in the ready cycle
	assign o_stall = (state != lsu_pkg::IDLE || req) && !i_ready && !ex;

endmodule

`default_nettype wire

/* hw/lsu_align.sv */
// Align stage: alignment check, byte-lane enables and store data positioning
// Purely combinational, sits between the core operands and the RAM
`timescale 1ns/1ns
`default_nettype none

module lsu_align (
	input  logic [1:0]          i_addr, // Byte offset within the word
	input  rv_mem_pkg::mem_f3_e i_f3,
	input  rv_mem_pkg::word_t   i_wr_data,
	input  logic                i_wr_en,
	input  logic                i_rd_en,
	output rv_mem_pkg::byte_en_t o_byte_en,
	output rv_mem_pkg::word_t   o_st_word,
	output logic                o_ex_ld,
	output logic                o_ex_st
);

	logic is_half;
	logic is_word;
	logic misaligned;

	assign is_half = (i_f3 == rv_mem_pkg::F3_H) || (i_f3 == rv_mem_pkg::F3_HU);
	assign is_word = (i_f3 == rv_mem_pkg::F3_W);

	// Halfword needs an even address, word needs offset zero
	always_comb begin
		misaligned = 1'b0;
		if (is_half) begin
			misaligned = i_addr[0];
		end else if (is_word) begin
			misaligned = |i_addr;
		end
	end

	assign o_ex_ld = i_rd_en && misaligned;
	assign o_ex_st = i_wr_en && misaligned;

	// Lanes written by SB, SH and SW
	always_comb begin
		case (i_f3)
			rv_mem_pkg::F3_B: begin
				o_byte_en = rv_mem_pkg::byte_en_t'(4'b0001 << i_addr);
			end
			rv_mem_pkg::F3_H: begin
				o_byte_en = i_addr[1] ? 4'b1100 : 4'b0011; // Upper or lower pair
			end
			rv_mem_pkg::F3_W: begin
				o_byte_en = 4'b1111;
			end
			default: begin
				o_byte_en = 4'b0000; // No store form
			end
		endcase
	end

	// Move the low bytes of the store data up to the addressed lane
	assign o_st_word = i_wr_data << {i_addr, 3'b000};

endmodule

`default_nettype wire

/* hw/lsu_defines.svh */
// Size and timing constants of the load/store unit and its data RAM
// Include wherever a width, the RAM depth or the RAM latency is needed
`ifndef LSU_DEFINES_SVH
`define LSU_DEFINES_SVH

// Data and address width
`define LSU_XLEN 32

// Word-address bits of the data RAM, 64 words
`define LSU_DMEM_AW 6

// Cycles from an accepted request to the ready pulse, at least 1
`define LSU_DMEM_LAT 2

`endif

/* hw/lsu_load_extend.sv */
// Load-extend stage: picks the addressed lane of the RAM word
// and sign- or zero-extends it according to funct3
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defines.svh"

module lsu_load_extend (
	input  rv_mem_pkg::word_t   i_raw,
	input  logic [1:0]          i_offset,
	input  rv_mem_pkg::mem_f3_e i_f3,
	output rv_mem_pkg::word_t   o_rd_data
);

	rv_mem_pkg::word_t shifted;

	// Addressed byte or halfword lands at bit 0
	assign shifted = i_raw >> {i_offset, 3'b000};

	always_comb begin
		case (i_f3)
			rv_mem_pkg::F3_B: begin
				o_rd_data = {{(`LSU_XLEN-8){shifted[7]}}, shifted[7:0]};
			end
			rv_mem_pkg::F3_H: begin
				o_rd_data = {{(`LSU_XLEN-16){shifted[15]}}, shifted[15:0]};
			end
			rv_mem_pkg::F3_BU: begin
				o_rd_data = {{(`LSU_XLEN-8){1'b0}}, shifted[7:0]};
			end
			rv_mem_pkg::F3_HU: begin
				o_rd_data = {{(`LSU_XLEN-16){1'b0}}, shifted[15:0]};
			end
			default: begin
				o_rd_data = shifted; // LW, offset is zero here
			end
		endcase
	end

endmodule

`default_nettype wire

/* hw/lsu_pkg.sv */
// Internal types of the load/store unit
// Access machine state and the RAM word index
`default_nettype none

`include "lsu_defines.svh"

package lsu_pkg;

	typedef enum logic [1:0] {
		IDLE  = 2'b00,
		READ  = 2'b01,
		WRITE = 2'b10
	} acc_state_e;

	typedef logic [`LSU_DMEM_AW-1:0] word_idx_t; // RAM word address

endpackage

`default_nettype wire

/* hw/lsu_top.sv */
// Load/store unit top: align, access and load-extend stages around the data RAM
// Connects straight to the core's memory-stage operands and stall input
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defines.svh"

module lsu_top (
	input  logic                i_clk,
	input  logic                i_rst_n,
	input  rv_mem_pkg::word_t   i_addr,
	input  rv_mem_pkg::mem_f3_e i_f3,
	input  rv_mem_pkg::word_t   i_wr_data,
	input  logic                i_wr_en,
	input  logic                i_rd_en,
	output rv_mem_pkg::word_t   o_rd_data,
	output logic                o_stall,
	output logic                o_ex_ld,
	output logic                o_ex_st
);

	rv_mem_pkg::byte_en_t byte_en;
	rv_mem_pkg::word_t    st_word;
	rv_mem_pkg::word_t    raw_word;
	logic                 mem_wen;
	logic                 mem_ren;
	logic                 ready;

	lsu_align u_align (
		.i_addr    (i_addr[1:0]),
		.i_f3      (i_f3),
		.i_wr_data (i_wr_data),
		.i_wr_en   (i_wr_en),
		.i_rd_en   (i_rd_en),
		.o_byte_en (byte_en),
		.o_st_word (st_word),
		.o_ex_ld   (o_ex_ld),
		.o_ex_st   (o_ex_st)
	);

	lsu_access_fsm u_access_fsm (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_wr_en   (i_wr_en),
		.i_rd_en   (i_rd_en),
		.i_ex_ld   (o_ex_ld),
		.i_ex_st   (o_ex_st),
		.i_ready   (ready),
		.o_mem_wen (mem_wen),
		.o_mem_ren (mem_ren),
		.o_stall   (o_stall)
	);

	dmem_ram u_ram (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_addr    (i_addr[`LSU_DMEM_AW+1:2]), // Word index
		.i_wen     (mem_wen),
		.i_ren     (mem_ren),
		.i_byte_en (byte_en),
		.i_wdata   (st_word),
		.o_rdata   (raw_word),
		.o_ready   (ready)
	);

	lsu_load_extend u_load_extend (
		.i_raw     (raw_word),
		.i_offset  (i_addr[1:0]),
		.i_f3      (i_f3),
		.o_rd_data (o_rd_data)
	);

endmodule

`default_nettype wire

/* hw/rv_mem_pkg.sv */
// ISA-level encoding of RV32 loads and stores
// Shared by the unit stages and the testbench through scoped names
`default_nettype none

`include "lsu_defines.svh"

package rv_mem_pkg;

	// funct3 width codes of LOAD/STORE
	typedef enum logic [2:0] {
		F3_B  = 3'b000,
		F3_H  = 3'b001,
		F3_W  = 3'b010,
		F3_BU = 3'b100,
		F3_HU = 3'b101
	} mem_f3_e;

	typedef logic [3:0] byte_en_t; // One bit per byte lane

	typedef logic [`LSU_XLEN-1:0] word_t;

endpackage

`default_nettype wire

/* tb/lsu_assertions.sv */
// Concurrent checks on the access state machine that the testbench binds in
// Covers request gating and stall under exceptions, and ready pulse timing
`timescale 1ns/1ns
`default_nettype none

module lsu_assertions (
	input logic                i_clk,
	input logic                i_rst_n,
	input logic                i_ex_ld,
	input logic                i_ex_st,
	input logic                i_ready,
	input logic                i_mem_wen,
	input logic                i_mem_ren,
	input logic                i_stall,
	input lsu_pkg::acc_state_e i_state
);

	int n_err = 0; // Failed assertions so far

	// A misaligned access never reaches the RAM
	a_no_req_on_ex: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_ex_ld || i_ex_st) |-> !(i_mem_wen || i_mem_ren))
		else begin
			n_err++;
			$error("memory enable high while an exception is present");
		end

	// A held misaligned access never stalls and never leaves IDLE
	a_no_stall_on_ex: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		(i_ex_ld || i_ex_st) |-> (!i_stall && (i_state == lsu_pkg::IDLE)))
		else begin
			n_err++;
			$error("stall high or machine busy while an exception is present");
		end

	// Ready answers a request, so the machine is busy
	a_ready_busy: assert property (@(posedge i_clk) disable iff (!i_rst_n)
		i_ready |-> (i_state != lsu_pkg::IDLE))
		else begin
			n_err++;
			$error("ready pulse while the access machine is idle");
		end

endmodule

`default_nettype wire

/* tb/lsu_tb.sv */
// Table-driven testbench for the load/store unit with a byte-level reference memory
// Compile with files.f and run lsu_tb as the top module
`timescale 1ns/1ns
`default_nettype none

`include "lsu_defines.svh"

module lsu_tb;

	localparam int NBYTES  = 4 * (2 ** `LSU_DMEM_AW);
	localparam int TIMEOUT = 50; // Cycles allowed per access

	logic                i_clk;
	logic                i_rst_n;
	rv_mem_pkg::word_t   i_addr;
	rv_mem_pkg::mem_f3_e i_f3;
	rv_mem_pkg::word_t   i_wr_data;
	logic                i_wr_en;
	logic                i_rd_en;
	rv_mem_pkg::word_t   o_rd_data;
	logic                o_stall;
	logic                o_ex_ld;
	logic                o_ex_st;

	// Stimulus table, one queue per column
	string               t_name[$];
	logic                t_write[$];
	rv_mem_pkg::mem_f3_e t_f3[$];
	rv_mem_pkg::word_t   t_addr[$];
	rv_mem_pkg::word_t   t_data[$];
	logic                t_trap[$]; // Misalignment expected

	logic [7:0]  ref_mem [NBYTES];
	logic [31:0] rng;
	int          n_pass;
	int          n_fail;
	int          errs;

	lsu_top u_dut (.*);

	bind lsu_access_fsm lsu_assertions u_assertions (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_ex_ld   (i_ex_ld),
		.i_ex_st   (i_ex_st),
		.i_ready   (i_ready),
		.i_mem_wen (o_mem_wen),
		.i_mem_ren (o_mem_ren),
		.i_stall   (o_stall),
		.i_state   (state)
	);

	initial i_clk = 1'b0;
	always #2 i_clk = ~i_clk;

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic rv_mem_pkg::word_t rand_word();
		rng = xorshift32(rng);
		return rng;
	endfunction

	task automatic add_entry(input string name, input logic wr, input rv_mem_pkg::mem_f3_e f3,
			input rv_mem_pkg::word_t addr, input rv_mem_pkg::word_t data, input logic trap);
		t_name.push_back(name);
		t_write.push_back(wr);
		t_f3.push_back(f3);
		t_addr.push_back(addr);
		t_data.push_back(data);
		t_trap.push_back(trap);
	endtask

	// Little-endian byte model, lane i of a word is byte address 4*w+i
	task automatic ref_store(input rv_mem_pkg::mem_f3_e f3, input rv_mem_pkg::word_t addr,
			input rv_mem_pkg::word_t data);
		int a;
		int n;
		a = int'(addr % NBYTES);
		n = (f3 == rv_mem_pkg::F3_B) ? 1 : (f3 == rv_mem_pkg::F3_H) ? 2 : 4;
		for (int i = 0; i < n; i++) begin
			ref_mem[a + i] = data[8*i +: 8];
		end
	endtask

	function automatic rv_mem_pkg::word_t ref_load(input rv_mem_pkg::mem_f3_e f3,
			input rv_mem_pkg::word_t addr);
		int a;
		a = int'(addr % NBYTES);
		case (f3)
			rv_mem_pkg::F3_B:  return {{24{ref_mem[a][7]}}, ref_mem[a]};
			rv_mem_pkg::F3_BU: return {24'h0, ref_mem[a]};
			rv_mem_pkg::F3_H:  return {{16{ref_mem[a+1][7]}}, ref_mem[a+1], ref_mem[a]};
			rv_mem_pkg::F3_HU: return {16'h0, ref_mem[a+1], ref_mem[a]};
			default:           return {ref_mem[a+3], ref_mem[a+2], ref_mem[a+1], ref_mem[a]};
		endcase
	endfunction

	task automatic check_word(input string name, input rv_mem_pkg::word_t exp,
			input rv_mem_pkg::word_t act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %h, actual %h", name, exp, act);
			errs++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("[ERROR] %s: expected %b, actual %b", name, exp, act);
			errs++;
		end
	endtask

	task automatic wait_stall_low(input string name, output logic ok);
		int cycles;
		cycles = 0;
		ok = 1'b1;
		while (o_stall !== 1'b0 && ok) begin
			if (cycles == TIMEOUT) begin
				$display("%s: o_stall stayed high for %0d cycles, access never finished",
					name, TIMEOUT);
				ok = 1'b0;
				errs++;
			end else begin
				@(negedge i_clk);
				cycles++;
			end
		end
	endtask

	task automatic build_table();
		rv_mem_pkg::word_t a;
		add_entry("sw_00", 1'b1, rv_mem_pkg::F3_W, 32'h00, rand_word(), 1'b0);
		add_entry("lw_00", 1'b0, rv_mem_pkg::F3_W, 32'h00, '0, 1'b0);
		add_entry("sw_04", 1'b1, rv_mem_pkg::F3_W, 32'h04, rand_word(), 1'b0);
		add_entry("lw_04", 1'b0, rv_mem_pkg::F3_W, 32'h04, '0, 1'b0);
		add_entry("sw_fc", 1'b1, rv_mem_pkg::F3_W, 32'hfc, rand_word(), 1'b0);
		add_entry("lw_fc", 1'b0, rv_mem_pkg::F3_W, 32'hfc, '0, 1'b0);
		// Byte and halfword stores merged into known words
		add_entry("sw_20", 1'b1, rv_mem_pkg::F3_W, 32'h20, 32'ha5a5_5a5a, 1'b0);
		for (int off = 0; off < 4; off++) begin
			a = 32'h20 + off;
			add_entry($sformatf("sb_%0h", a), 1'b1, rv_mem_pkg::F3_B, a, rand_word(), 1'b0);
			add_entry($sformatf("lw_20_after_sb_%0h", a), 1'b0, rv_mem_pkg::F3_W, 32'h20, '0, 1'b0);
		end
		add_entry("sw_24", 1'b1, rv_mem_pkg::F3_W, 32'h24, 32'hffff_0000, 1'b0);
		add_entry("sh_24", 1'b1, rv_mem_pkg::F3_H, 32'h24, rand_word(), 1'b0);
		add_entry("lw_24_after_sh_24", 1'b0, rv_mem_pkg::F3_W, 32'h24, '0, 1'b0);
		add_entry("sh_26", 1'b1, rv_mem_pkg::F3_H, 32'h26, rand_word(), 1'b0);
		add_entry("lw_24_after_sh_26", 1'b0, rv_mem_pkg::F3_W, 32'h24, '0, 1'b0);
		// Sign bits set and clear in different lanes
		add_entry("sw_30", 1'b1, rv_mem_pkg::F3_W, 32'h30, 32'h807f_ff01, 1'b0);
		add_entry("sw_34", 1'b1, rv_mem_pkg::F3_W, 32'h34, 32'h7fff_0080, 1'b0);
		for (int wi = 0; wi < 2; wi++) begin
			for (int off = 0; off < 4; off++) begin
				a = 32'h30 + 4 * wi + off;
				add_entry($sformatf("lb_%0h", a), 1'b0, rv_mem_pkg::F3_B, a, '0, 1'b0);
				add_entry($sformatf("lbu_%0h", a), 1'b0, rv_mem_pkg::F3_BU, a, '0, 1'b0);
				if (off % 2 == 0) begin
					add_entry($sformatf("lh_%0h", a), 1'b0, rv_mem_pkg::F3_H, a, '0, 1'b0);
					add_entry($sformatf("lhu_%0h", a), 1'b0, rv_mem_pkg::F3_HU, a, '0, 1'b0);
				end
			end
		end
		// Misaligned forms trap and leave memory alone
		add_entry("sw_40", 1'b1, rv_mem_pkg::F3_W, 32'h40, rand_word(), 1'b0);
		add_entry("lh_41", 1'b0, rv_mem_pkg::F3_H, 32'h41, '0, 1'b1);
		add_entry("lhu_43", 1'b0, rv_mem_pkg::F3_HU, 32'h43, '0, 1'b1);
		add_entry("lw_42", 1'b0, rv_mem_pkg::F3_W, 32'h42, '0, 1'b1);
		add_entry("sh_41", 1'b1, rv_mem_pkg::F3_H, 32'h41, rand_word(), 1'b1);
		add_entry("sw_42", 1'b1, rv_mem_pkg::F3_W, 32'h42, rand_word(), 1'b1);
		add_entry("sw_43", 1'b1, rv_mem_pkg::F3_W, 32'h43, rand_word(), 1'b1);
		add_entry("lw_40_unchanged", 1'b0, rv_mem_pkg::F3_W, 32'h40, '0, 1'b0);
	endtask

	initial begin
		logic ok;
		i_rst_n   = 1'b0;
		i_addr    = '0;
		i_f3      = rv_mem_pkg::F3_W;
		i_wr_data = '0;
		i_wr_en   = 1'b0;
		i_rd_en   = 1'b0;
		rng       = 32'he6cc_5571;
		n_pass    = 0;
		n_fail    = 0;
		ok        = 1'b1;
		build_table();

		// Two reset cycles, then one idle cycle, no enable present
		errs = 0;
		for (int c = 0; c < 3; c++) begin
			@(negedge i_clk);
			check_flag("reset_idle o_stall", 1'b0, o_stall);
			check_flag("reset_idle o_ex_ld", 1'b0, o_ex_ld);
			check_flag("reset_idle o_ex_st", 1'b0, o_ex_st);
			i_rst_n = (c >= 1);
		end
		if (errs == 0) begin
			n_pass++;
			$display("Test reset_idle passed");
		end else begin
			n_fail++;
			$display("Test reset_idle failed");
		end

		for (int k = 0; k < t_name.size(); k++) begin
			errs = 0;
			@(negedge i_clk);
			i_addr    = t_addr[k];
			i_f3      = t_f3[k];
			i_wr_data = t_data[k];
			i_wr_en   = t_write[k];
			i_rd_en   = !t_write[k];
			#1;
			check_flag({t_name[k], " o_ex_ld"}, t_trap[k] && !t_write[k], o_ex_ld);
			check_flag({t_name[k], " o_ex_st"}, t_trap[k] && t_write[k], o_ex_st);
			check_flag({t_name[k], " o_stall"}, !t_trap[k], o_stall);
			wait_stall_low(t_name[k], ok);
			if (ok && !t_trap[k] && !t_write[k]) begin
				check_word(t_name[k], ref_load(t_f3[k], t_addr[k]), o_rd_data);
			end
			if (!t_trap[k] && t_write[k]) begin
				ref_store(t_f3[k], t_addr[k], t_data[k]);
			end
			if (t_trap[k]) begin
				@(negedge i_clk); // Hold the trapping access across one edge
			end
			i_wr_en = 1'b0;
			i_rd_en = 1'b0;
			if (errs == 0) begin
				n_pass++;
				$display("Test %s passed", t_name[k]);
			end else begin
				n_fail++;
				$display("Test %s failed", t_name[k]);
			end
			if (!ok) begin
				break;
			end
		end

		repeat (2) @(negedge i_clk);
		$display("Tests passed: %0d, failed: %0d, assertion failures: %0d",
			n_pass, n_fail, u_dut.u_access_fsm.u_assertions.n_err);
		if (n_fail == 0 && ok && u_dut.u_access_fsm.u_assertions.n_err == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire
